/* vga_pkg.sv */
package vga_pkg;

  // Raster coordinate and 4:4:4 colour
  typedef logic [11:0] coord_t;
  typedef logic [11:0] rgb_t;

  // 1024x768 timing, counts start at zero
  localparam coord_t H_ACTIVE     = 12'd1024;
  localparam coord_t H_TOTAL      = 12'd1344;
  localparam coord_t H_SYNC_START = 12'd1048;
  localparam coord_t H_SYNC_END   = 12'd1184;

  localparam coord_t V_ACTIVE     = 12'd768;
  localparam coord_t V_TOTAL      = 12'd806;
  localparam coord_t V_SYNC_START = 12'd771;
  localparam coord_t V_SYNC_END   = 12'd777;

  // Background
  localparam coord_t HORIZON_Y = 12'd600;
  localparam rgb_t   FLOOR_RGB = 12'h4_6_2;
  localparam rgb_t   BACK_RGB  = 12'h1_2_6;
  localparam rgb_t   BLACK_RGB = 12'h0_0_0;
  localparam rgb_t   WHITE_RGB = 12'hf_f_f;

endpackage

/* game_pkg.sv */
package game_pkg;

  typedef enum logic [1:0] {
    LASER_IDLE,
    LASER_LEFT,
    LASER_MIDDLE,
    LASER_RIGHT
  } laser_state_t;

  typedef logic [24:0] period_t;
  typedef logic [1:0]  cfg_addr_t;

  // Vertical extent of every beam
  localparam vga_pkg::coord_t LASER_TOP    = 12'd317;
  localparam vga_pkg::coord_t LASER_BOTTOM = 12'd617;

  // Left edge at beam start, right edge starts one above
  localparam vga_pkg::coord_t BAY_LEFT_C   = 12'd411;
  localparam vga_pkg::coord_t BAY_MIDDLE_C = 12'd511;
  localparam vga_pkg::coord_t BAY_RIGHT_C  = 12'd611;

  // Beam is full at centre-30 .. centre+21
  localparam int HALF_WIDTH     = 30;
  localparam int FULL_RIGHT_OFS = 21;

  localparam logic [3:0] LEVEL_LASER = 4'd1;

  localparam int PLAYER_SIZE = 32;

  localparam cfg_addr_t CFG_STEP  = 2'd0;
  localparam cfg_addr_t CFG_HOLD  = 2'd1;
  localparam cfg_addr_t CFG_COLOR = 2'd2;

  localparam period_t DEFAULT_STEP = 25'd3200000;
  localparam period_t DEFAULT_HOLD = 25'd32000000;

endpackage

/* vga_timing.sv */
`timescale 1ns/1ns

module vga_timing
  import vga_pkg::*;
(
  input  logic   pclk,
  input  logic   rst,
  output coord_t hcount,
  output coord_t vcount,
  output logic   hsync,
  output logic   vsync,
  output logic   blank
);

  coord_t h_nxt;
  coord_t v_nxt;

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    h_nxt = hcount + 12'd1;
    v_nxt = vcount;
    if (hcount == H_TOTAL - 12'd1) begin
      h_nxt = '0;
      if (vcount == V_TOTAL - 12'd1) begin
        v_nxt = '0;
      end else begin
        v_nxt = vcount + 12'd1;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
    end else begin
      hcount <= h_nxt;
      vcount <= v_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sync and blank
  //////////////////////////////////////////////////////////////////////

  // Decoded from the next count so the flags line up with hcount
  always_ff @(posedge pclk) begin
    if (rst) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      blank <= 1'b1;
    end else begin
      hsync <= (h_nxt >= H_SYNC_START) && (h_nxt < H_SYNC_END);
      vsync <= (v_nxt >= V_SYNC_START) && (v_nxt < V_SYNC_END);
      blank <= (h_nxt >= H_ACTIVE) || (v_nxt >= V_ACTIVE);
    end
  end

endmodule

/* background_draw.sv */
`timescale 1ns/1ns

module background_draw
  import vga_pkg::*;
(
  input  logic   pclk,
  input  logic   rst,
  input  coord_t hcount_in,
  input  coord_t vcount_in,
  input  logic   hsync_in,
  input  logic   vsync_in,
  input  logic   blank_in,
  output coord_t hcount_out,
  output coord_t vcount_out,
  output logic   hsync_out,
  output logic   vsync_out,
  output logic   blank_out,
  output rgb_t   rgb_out
);

  always_ff @(posedge pclk) begin
    if (rst) begin
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
      blank_out <= 1'b1;
      rgb_out   <= BLACK_RGB;
    end else begin
      hsync_out <= hsync_in;
      vsync_out <= vsync_in;
      blank_out <= blank_in;
      if (blank_in) begin
        rgb_out <= BLACK_RGB;
      end else if (vcount_in >= HORIZON_Y) begin
        // Floor from the horizon line down
        rgb_out <= FLOOR_RGB;
      end else begin
        rgb_out <= BACK_RGB;
      end
    end
  end

  always_ff @(posedge pclk) begin
    hcount_out <= hcount_in;
    vcount_out <= vcount_in;
  end

endmodule

/* laser_cfg_regs.sv */
`timescale 1ns/1ns

module laser_cfg_regs
  import vga_pkg::*;
  import game_pkg::*;
(
  input  logic      pclk,
  input  logic      rst,
  input  logic      cfg_we,
  input  cfg_addr_t cfg_addr,
  input  period_t   cfg_wdata,
  output period_t   step_period,
  output period_t   hold_period,
  output rgb_t      laser_rgb
);

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  // Defaults give the hardware sweep speed
  always_ff @(posedge pclk) begin
    if (rst) begin
      step_period <= DEFAULT_STEP;
      hold_period <= DEFAULT_HOLD;
      laser_rgb   <= WHITE_RGB;
    end else if (cfg_we) begin
      case (cfg_addr)
        CFG_STEP: begin
          step_period <= cfg_wdata;
        end
        CFG_HOLD: begin
          hold_period <= cfg_wdata;
        end
        CFG_COLOR: begin
          // Colour sits in the low bits
          laser_rgb <= cfg_wdata[11:0];
        end
        default: begin
          step_period <= step_period;
        end
      endcase
    end
  end

endmodule

/* laser_obstacle.sv */
`timescale 1ns/1ns

module laser_obstacle
  import vga_pkg::*;
  import game_pkg::*;
(
  input  logic       pclk,
  input  logic       rst,
  input  coord_t     hcount_in,
  input  coord_t     vcount_in,
  input  logic       hsync_in,
  input  logic       vsync_in,
  input  logic       blank_in,
  input  rgb_t       rgb_in,
  input  logic       start,
  input  logic       abort,
  input  logic [3:0] level,
  input  period_t    step_period,
  input  period_t    hold_period,
  input  rgb_t       laser_rgb,
  output coord_t     hcount_out,
  output coord_t     vcount_out,
  output logic       hsync_out,
  output logic       vsync_out,
  output logic       blank_out,
  output rgb_t       rgb_out,
  output logic       laser_px,
  output logic       working,
  output logic       done
);

  laser_state_t state, state_nxt;
  coord_t       left, left_nxt;
  coord_t       right, right_nxt;
  period_t      grow_cnt, grow_cnt_nxt;
  period_t      hold_cnt, hold_cnt_nxt;
  logic         reverse, reverse_nxt;
  logic         done_nxt;
  coord_t       centre;
  logic         full;
  logic         in_beam;

  function automatic coord_t bay_centre(input laser_state_t s);
    case (s)
      LASER_MIDDLE: return BAY_MIDDLE_C;
      LASER_RIGHT:  return BAY_RIGHT_C;
      default:      return BAY_LEFT_C;
    endcase
  endfunction

  assign centre = bay_centre(state);
  assign full   = (left <= centre - HALF_WIDTH) && (right >= centre + FULL_RIGHT_OFS);

  //////////////////////////////////////////////////////////////////////
  // Sweep FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt    = state;
    left_nxt     = left;
    right_nxt    = right;
    grow_cnt_nxt = grow_cnt;
    hold_cnt_nxt = hold_cnt;
    reverse_nxt  = reverse;
    done_nxt     = 1'b0;
    if (state == LASER_IDLE) begin
      if (start && (level == LEVEL_LASER)) begin
        state_nxt    = LASER_LEFT;
        reverse_nxt  = 1'b0;
        left_nxt     = BAY_LEFT_C;
        right_nxt    = BAY_LEFT_C + 12'd1;
        grow_cnt_nxt = '0;
        hold_cnt_nxt = '0;
      end
    end else if (abort) begin
      state_nxt = LASER_IDLE;
    end else if (!full) begin
      // Widen one pixel per side
      if (grow_cnt >= step_period) begin
        left_nxt     = left - 12'd1;
        right_nxt    = right + 12'd1;
        grow_cnt_nxt = '0;
      end else begin
        grow_cnt_nxt = grow_cnt + 25'd1;
      end
    end else if (hold_cnt >= hold_period) begin
      grow_cnt_nxt = '0;
      hold_cnt_nxt = '0;
      case (state)
        LASER_LEFT: begin
          if (reverse) begin
            state_nxt = LASER_IDLE;
            done_nxt  = 1'b1;
          end else begin
            state_nxt = LASER_MIDDLE;
          end
        end
        LASER_MIDDLE: begin
          state_nxt = reverse ? LASER_LEFT : LASER_RIGHT;
        end
        LASER_RIGHT: begin
          // Right bay runs twice, the second pass turns the sweep around
          state_nxt   = reverse ? LASER_MIDDLE : LASER_RIGHT;
          reverse_nxt = 1'b1;
        end
        default: begin
          state_nxt = LASER_IDLE;
        end
      endcase
      left_nxt  = bay_centre(state_nxt);
      right_nxt = bay_centre(state_nxt) + 12'd1;
    end else begin
      hold_cnt_nxt = hold_cnt + 25'd1;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      state    <= LASER_IDLE;
      left     <= '0;
      right    <= '0;
      grow_cnt <= '0;
      hold_cnt <= '0;
      reverse  <= 1'b0;
      done     <= 1'b0;
      working  <= 1'b0;
    end else begin
      state    <= state_nxt;
      left     <= left_nxt;
      right    <= right_nxt;
      grow_cnt <= grow_cnt_nxt;
      hold_cnt <= hold_cnt_nxt;
      reverse  <= reverse_nxt;
      done     <= done_nxt;
      working  <= (state != LASER_IDLE);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pixel overlay
  //////////////////////////////////////////////////////////////////////

  assign in_beam = (state != LASER_IDLE) && !blank_in &&
                   (hcount_in >= left) && (hcount_in <= right) &&
                   (vcount_in >= LASER_TOP) && (vcount_in <= LASER_BOTTOM);

  always_ff @(posedge pclk) begin
    if (rst) begin
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
      blank_out <= 1'b1;
      laser_px  <= 1'b0;
      rgb_out   <= BLACK_RGB;
    end else begin
      hsync_out <= hsync_in;
      vsync_out <= vsync_in;
      blank_out <= blank_in;
      laser_px  <= in_beam;
      rgb_out   <= in_beam ? laser_rgb : rgb_in;
    end
  end

  always_ff @(posedge pclk) begin
    hcount_out <= hcount_in;
    vcount_out <= vcount_in;
  end

endmodule

/* hit_detect.sv */
`timescale 1ns/1ns

module hit_detect
  import vga_pkg::*;
  import game_pkg::*;
(
  input  logic   pclk,
  input  logic   rst,
  input  coord_t hcount,
  input  coord_t vcount,
  input  logic   laser_px,
  input  coord_t player_x,
  input  coord_t player_y,
  input  logic   clear,
  output logic   hit
);

  coord_t dx;
  coord_t dy;
  logic   in_box;

  // Offsets into the player box, guarded against wrap
  assign dx = hcount - player_x;
  assign dy = vcount - player_y;

  assign in_box = (hcount >= player_x) && (dx < PLAYER_SIZE) &&
                  (vcount >= player_y) && (dy < PLAYER_SIZE);

  //////////////////////////////////////////////////////////////////////
  // Hit flag
  //////////////////////////////////////////////////////////////////////

  // Sticky until the player restarts
  always_ff @(posedge pclk) begin
    if (rst) begin
      hit <= 1'b0;
    end else if (clear) begin
      hit <= 1'b0;
    end else if (laser_px && in_box) begin
      hit <= 1'b1;
    end
  end

endmodule

/* laser_game_top.sv */
`timescale 1ns/1ns

module laser_game_top
  import vga_pkg::*;
  import game_pkg::*;
(
  input  logic       pclk,
  input  logic       rst,
  input  logic       start,
  input  logic       abort,
  input  logic [3:0] level,
  input  logic       cfg_we,
  input  cfg_addr_t  cfg_addr,
  input  period_t    cfg_wdata,
  input  coord_t     player_x,
  input  coord_t     player_y,
  input  logic       clear,
  output logic       hsync,
  output logic       vsync,
  output rgb_t       rgb_out,
  output logic       working,
  output logic       done,
  output logic       hit
);

  // Timing stage
  coord_t  tim_hcount, tim_vcount;
  logic    tim_hsync, tim_vsync, tim_blank;
  // Background stage
  coord_t  bg_hcount, bg_vcount;
  logic    bg_hsync, bg_vsync, bg_blank;
  rgb_t    bg_rgb;
  // Laser stage
  coord_t  las_hcount, las_vcount;
  logic    laser_px;
  period_t step_period, hold_period;
  rgb_t    laser_rgb;

  vga_timing u_vga_timing (
    .pclk   (pclk),
    .rst    (rst),
    .hcount (tim_hcount),
    .vcount (tim_vcount),
    .hsync  (tim_hsync),
    .vsync  (tim_vsync),
    .blank  (tim_blank)
  );

  background_draw u_background_draw (
    .pclk       (pclk),
    .rst        (rst),
    .hcount_in  (tim_hcount),
    .vcount_in  (tim_vcount),
    .hsync_in   (tim_hsync),
    .vsync_in   (tim_vsync),
    .blank_in   (tim_blank),
    .hcount_out (bg_hcount),
    .vcount_out (bg_vcount),
    .hsync_out  (bg_hsync),
    .vsync_out  (bg_vsync),
    .blank_out  (bg_blank),
    .rgb_out    (bg_rgb)
  );

  laser_cfg_regs u_laser_cfg_regs (
    .pclk        (pclk),
    .rst         (rst),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .step_period (step_period),
    .hold_period (hold_period),
    .laser_rgb   (laser_rgb)
  );

  // Blank is not needed past the last stage
  laser_obstacle u_laser_obstacle (
    .pclk        (pclk),
    .rst         (rst),
    .hcount_in   (bg_hcount),
    .vcount_in   (bg_vcount),
    .hsync_in    (bg_hsync),
    .vsync_in    (bg_vsync),
    .blank_in    (bg_blank),
    .rgb_in      (bg_rgb),
    .start       (start),
    .abort       (abort),
    .level       (level),
    .step_period (step_period),
    .hold_period (hold_period),
    .laser_rgb   (laser_rgb),
    .hcount_out  (las_hcount),
    .vcount_out  (las_vcount),
    .hsync_out   (hsync),
    .vsync_out   (vsync),
    .blank_out   (),
    .rgb_out     (rgb_out),
    .laser_px    (laser_px),
    .working     (working),
    .done        (done)
  );

  hit_detect u_hit_detect (
    .pclk     (pclk),
    .rst      (rst),
    .hcount   (las_hcount),
    .vcount   (las_vcount),
    .laser_px (laser_px),
    .player_x (player_x),
    .player_y (player_y),
    .clear    (clear),
    .hit      (hit)
  );

endmodule

/* tb_laser_tasks.svh */
`ifndef TB_LASER_TASKS_SVH
`define TB_LASER_TASKS_SVH

// Compare one observed value with its expected value
task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
    $display("*** FAILED ***");
    $fatal(1, "Mismatch on %s", name);
  end
endtask

// One register write, visible on the next pclk
task automatic write_cfg(input cfg_addr_t addr, input period_t data);
  @(posedge pclk);
  cfg_we    <= 1'b1;
  cfg_addr  <= addr;
  cfg_wdata <= data;
  @(posedge pclk);
  cfg_we <= 1'b0;
endtask

function automatic logic in_laser(input logic active, input coord_t left, input coord_t right,
                                  input coord_t h, input coord_t v, input logic blank);
  return active && !blank && (h >= left) && (h <= right) &&
         (v >= LASER_TOP) && (v <= LASER_BOTTOM);
endfunction

// Expected colour of one pixel, laser on top of the background
function automatic rgb_t ref_pixel(input logic active, input coord_t left, input coord_t right,
                                   input coord_t h, input coord_t v, input logic blank,
                                   input rgb_t color);
  if (in_laser(active, left, right, h, v, blank)) begin
    return color;
  end
  if (blank) begin
    return BLACK_RGB;
  end
  if (v >= HORIZON_Y) begin
    return FLOOR_RGB;
  end
  return BACK_RGB;
endfunction

function automatic logic in_box(input coord_t h, input coord_t v, input coord_t x,
                                input coord_t y);
  int dx;
  int dy;
  dx = int'(h) - int'(x);
  dy = int'(v) - int'(y);
  return (dx >= 0) && (dx < PLAYER_SIZE) && (dy >= 0) && (dy < PLAYER_SIZE);
endfunction

`endif

/* tb_laser_game.sv */
`timescale 1ns/1ns

module tb_laser_game
  import vga_pkg::*;
  import game_pkg::*;
();

  localparam int TEST_STEP    = 1;
  localparam int TEST_HOLD    = 3;
  localparam int LONG_HOLD    = 2700;
  localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
  localparam int SWEEP_CYCLES = 6 * (HALF_WIDTH * (TEST_STEP + 1) + LONG_HOLD + 1);
  localparam int WATCH_CYCLES = 4 * SWEEP_CYCLES + 2 * FRAME_CYCLES;

  logic       pclk;
  logic       rst;
  logic       start;
  logic       abort;
  logic [3:0] level;
  logic       cfg_we;
  cfg_addr_t  cfg_addr;
  period_t    cfg_wdata;
  coord_t     player_x;
  coord_t     player_y;
  logic       clear;
  logic       hsync;
  logic       vsync;
  rgb_t       rgb_out;
  logic       working;
  logic       done;
  logic       hit;

  // Reference raster, one register per pipeline stage
  coord_t  m_h, m_v, p_h, p_v, e_h, e_v;
  logic    m_blank, p_blank;
  logic    e_hs, e_vs, e_px, e_hit;
  rgb_t    e_rgb;
  // Reference config and beam
  period_t m_step, m_hold;
  rgb_t    m_color;
  logic    b_on, b_done, b_working;
  coord_t  b_left, b_right;
  int      b_idx;
  int      b_cnt;
  logic    chk_en;
  integer  seed;

  laser_game_top dut (
    .pclk      (pclk),
    .rst       (rst),
    .start     (start),
    .abort     (abort),
    .level     (level),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .player_x  (player_x),
    .player_y  (player_y),
    .clear     (clear),
    .hsync     (hsync),
    .vsync     (vsync),
    .rgb_out   (rgb_out),
    .working   (working),
    .done      (done),
    .hit       (hit)
  );

  `include "tb_laser_tasks.svh"

  // Sweep order is left, middle, right, right, middle, left
  function automatic coord_t bay_of(input int idx);
    case (idx)
      1, 4:    return BAY_MIDDLE_C;
      2, 3:    return BAY_RIGHT_C;
      default: return BAY_LEFT_C;
    endcase
  endfunction

  initial begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;
  end

  initial begin
    repeat (WATCH_CYCLES) @(posedge pclk);
    $display("Watchdog expired after %0d cycles", WATCH_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "Watchdog timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  always @(posedge pclk) begin
    if (rst) begin
      m_step  <= DEFAULT_STEP;
      m_hold  <= DEFAULT_HOLD;
      m_color <= WHITE_RGB;
    end else if (cfg_we) begin
      if (cfg_addr == CFG_STEP) begin
        m_step <= cfg_wdata;
      end else if (cfg_addr == CFG_HOLD) begin
        m_hold <= cfg_wdata;
      end else if (cfg_addr == CFG_COLOR) begin
        m_color <= cfg_wdata[11:0];
      end
    end
  end

  always @(posedge pclk) begin : raster_model
    coord_t nh;
    coord_t nv;
    nh = (m_h == H_TOTAL - 12'd1) ? 12'd0 : m_h + 12'd1;
    nv = m_v;
    if (m_h == H_TOTAL - 12'd1) begin
      nv = (m_v == V_TOTAL - 12'd1) ? 12'd0 : m_v + 12'd1;
    end
    p_h <= m_h;
    p_v <= m_v;
    e_h <= p_h;
    e_v <= p_v;
    if (rst) begin
      m_h     <= '0;
      m_v     <= '0;
      m_blank <= 1'b1;
      p_blank <= 1'b1;
      e_rgb   <= BLACK_RGB;
      e_hs    <= 1'b0;
      e_vs    <= 1'b0;
      e_px    <= 1'b0;
      e_hit   <= 1'b0;
    end else begin
      m_h     <= nh;
      m_v     <= nv;
      m_blank <= (nh >= H_ACTIVE) || (nv >= V_ACTIVE);
      p_blank <= m_blank;
      e_rgb   <= ref_pixel(b_on, b_left, b_right, p_h, p_v, p_blank, m_color);
      e_px    <= in_laser(b_on, b_left, b_right, p_h, p_v, p_blank);
      e_hs    <= (p_h >= H_SYNC_START) && (p_h < H_SYNC_END);
      e_vs    <= (p_v >= V_SYNC_START) && (p_v < V_SYNC_END);
      if (clear) begin
        e_hit <= 1'b0;
      end else if (e_px && in_box(e_h, e_v, player_x, player_y)) begin
        e_hit <= 1'b1;
      end
    end
  end

  // One counter serves both growth and hold
  always @(posedge pclk) begin : beam_model
    coord_t c;
    logic   full;
    c    = bay_of(b_idx);
    full = (b_left <= c - HALF_WIDTH) && (b_right >= c + FULL_RIGHT_OFS);
    b_done <= 1'b0;
    if (rst) begin
      b_on      <= 1'b0;
      b_idx     <= 0;
      b_cnt     <= 0;
      b_left    <= '0;
      b_right   <= '0;
      b_working <= 1'b0;
    end else begin
      b_working <= b_on;
      if (!b_on) begin
        if (start && (level == LEVEL_LASER)) begin
          b_on    <= 1'b1;
          b_idx   <= 0;
          b_cnt   <= 0;
          b_left  <= bay_of(0);
          b_right <= bay_of(0) + 12'd1;
        end
      end else if (abort) begin
        b_on <= 1'b0;
      end else if (!full) begin
        if (b_cnt == m_step) begin
          b_left  <= b_left - 12'd1;
          b_right <= b_right + 12'd1;
          b_cnt   <= 0;
        end else begin
          b_cnt <= b_cnt + 1;
        end
      end else if (b_cnt == m_hold) begin
        b_cnt <= 0;
        if (b_idx == 5) begin
          b_on   <= 1'b0;
          b_done <= 1'b1;
        end else begin
          b_idx   <= b_idx + 1;
          b_left  <= bay_of(b_idx + 1);
          b_right <= bay_of(b_idx + 1) + 12'd1;
        end
      end else begin
        b_cnt <= b_cnt + 1;
      end
    end
  end

  always @(negedge pclk) begin
    if (chk_en) begin
      check_val("rgb_out", rgb_out, e_rgb);
      check_val("hsync", hsync, e_hs);
      check_val("vsync", vsync, e_vs);
      check_val("working", working, b_working);
      check_val("done", done, b_done);
      check_val("hit", hit, e_hit);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_pos(input int line, input int col);
    @(posedge pclk);
    while (!((m_v == line) && (m_h == col))) begin
      @(posedge pclk);
    end
  endtask

  task automatic run_sweep(input int line, input int col);
    int n;
    wait_pos(line, col);
    start <= 1'b1;
    @(posedge pclk);
    start <= 1'b0;
    repeat (3) @(posedge pclk);
    @(negedge pclk);
    check_val("working", working, 1'b1);
    n = 0;
    while ((done !== 1'b1) && (n < SWEEP_CYCLES + 100)) begin
      @(posedge pclk);
      n++;
    end
    if (done !== 1'b1) begin
      $display("Laser sweep gave no done pulse within %0d cycles", n);
      $display("*** FAILED ***");
      $fatal(1, "Sweep timeout");
    end
  endtask

  initial begin
    seed      = 81258;
    chk_en    = 1'b0;
    rst       = 1'b1;
    start     = 1'b0;
    abort     = 1'b0;
    level     = 4'd0;
    cfg_we    = 1'b0;
    cfg_addr  = CFG_STEP;
    cfg_wdata = '0;
    player_x  = 12'd900;
    player_y  = 12'd100;
    clear     = 1'b0;
    @(posedge pclk);
    chk_en <= 1'b1;
    repeat (2) @(posedge pclk);
    rst <= 1'b0;
    write_cfg(CFG_STEP, TEST_STEP);
    write_cfg(CFG_HOLD, TEST_HOLD);

    // Start with another level leaves the obstacle idle
    level <= 4'd2;
    wait_pos(320, 381);
    start <= 1'b1;
    @(posedge pclk);
    start <= 1'b0;
    repeat (100) @(posedge pclk);
    level <= 4'd1;
    @(negedge pclk);
    check_val("working", working, 1'b0);

    // Full sweeps, each started at a new raster column
    for (int i = 0; i < 8; i++) begin
      run_sweep(324 + 2 * i, 340 + 20 * i);
    end

    wait_pos(342, 400);
    start <= 1'b1;
    @(posedge pclk);
    start <= 1'b0;
    repeat (40) @(posedge pclk);
    abort <= 1'b1;
    @(posedge pclk);
    abort <= 1'b0;
    repeat (3) @(posedge pclk);
    @(negedge pclk);
    check_val("working", working, 1'b0);

    // Player on the middle bay, long hold so the beam spans whole lines
    write_cfg(CFG_HOLD, LONG_HOLD);
    player_x <= 12'd495 + ({$random(seed)} % 8);
    player_y <= 12'd350 + ({$random(seed)} % 30);
    @(posedge pclk);
    run_sweep(player_y + 2, 0);
    @(negedge pclk);
    check_val("hit", hit, 1'b1);
    @(posedge pclk);
    clear <= 1'b1;
    @(posedge pclk);
    clear <= 1'b0;
    @(negedge pclk);
    check_val("hit", hit, 1'b0);

    // Player right of every bay
    @(posedge pclk);
    player_x <= 12'd700 + ({$random(seed)} % 200);
    player_y <= 12'd410 + ({$random(seed)} % 20);
    @(posedge pclk);
    run_sweep(player_y + 2, 0);
    @(negedge pclk);
    check_val("hit", hit, 1'b0);

    write_cfg(CFG_HOLD, TEST_HOLD);
    write_cfg(CFG_COLOR, 25'h0000f0f);
    run_sweep(460, 381);
    repeat (10) @(posedge pclk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
vga_pkg.sv
game_pkg.sv
vga_timing.sv
background_draw.sv
laser_cfg_regs.sv
laser_obstacle.sv
hit_detect.sv
laser_game_top.sv
tb_laser_game.sv
